// File: sim/cpu_trace.txt
# T name | P imem address (hex) and word (binary op rb ra) | E out_data (hex) | X end
# each program clears the registers it uses, tests follow without reset
T alu_shift
P 000 001001001
P 001 001010010
P 002 011111111
P 003 000000000
P 004 000000000
P 005 000000000
P 006 010000010
P 007 000000000
P 008 111010000
P 009 010000000
P 00a 010000010
P 00b 001010001
P 00c 001000001
P 00d 111001000
P 00e 111001001
P 00f 111000000
E e0
E e3
X
T mem_branch
P 000 001111111
P 001 001001001
P 002 011111111
P 003 001000111
P 004 000111111
P 005 000111111
P 006 101111000
P 007 011000011
P 008 000000111
P 009 101000111
P 00a 101111000
P 00b 001000001
P 00c 111001001
P 00d 000111001
P 00e 110010010
P 00f 110001101
P 010 110100010
P 011 110110010
P 012 111001111
P 013 100010000
P 014 111001010
P 015 011111111
P 016 100011000
P 017 100100111
P 018 111001011
P 019 111001100
P 01a 111000000
E 03
E 02
E 01
E ff
E fc
E 03
X

// File: compile.f
design/cpu_pkg.sv
design/fetch_unit.sv
design/decoder.sv
design/reg_file.sv
design/exec_unit.sv
design/data_mem.sv
design/cpu_top.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := cpu_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/cpu_tb.sv
// cpu testbench: boots trace programs into the core, starts them and waits for done
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

  localparam int pc_width   = 10;
  localparam int clk_period = 8;
  localparam int rst_cycles = 5;

  logic                   clk, arst_n, req, prog_we;
  logic [pc_width-1:0]    prog_addr;
  logic [instr_width-1:0] prog_data;
  logic                   done, out_valid;
  logic [data_width-1:0]  out_data;
  int                     chk_errors;           // from the checker
  int                     tb_errors;            // control and trace problems
  int                     watch_cycles;         // watchdog budget

  string                  names[$];             // one entry per test
  int                     prog_start[$], prog_len[$], exp_start[$], exp_len[$];
  logic [pc_width-1:0]    p_addr[$];
  logic [instr_width-1:0] p_word[$];
  logic [data_width-1:0]  e_val[$];

  cpu_top #(.pc_width(pc_width)) DUT (
    .clk, .arst_n, .req, .prog_we, .prog_addr, .prog_data,
    .done, .out_valid, .out_data
  );

  cpu_checker chk (
    .clk, .arst_n, .out_valid, .out_data, .done, .errors(chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  // whole trace up front so the watchdog knows the budget
  task automatic read_trace();
    int                     fd;
    int                     cnt;
    string                  tag, name, rest;
    logic [pc_width-1:0]    a;
    logic [instr_width-1:0] w;
    logic [data_width-1:0]  v;
    fd = $fopen("sim/cpu_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file sim/cpu_trace.txt");
      tb_errors++;
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag == "#") begin
          cnt = $fgets(rest, fd);                // comment line
        end else if (tag == "T") begin
          cnt = $fscanf(fd, "%s", name);
          if (cnt != 1) begin
            $display("a test in the trace file has no name");
            tb_errors++;
          end
          names.push_back(name);
          prog_start.push_back(p_word.size());
          exp_start.push_back(e_val.size());
        end else if (tag == "P") begin
          cnt = $fscanf(fd, "%h %b", a, w);      // address hex, word binary
          if (cnt != 2) begin
            $display("a program line in the trace file is malformed");
            tb_errors++;
          end
          p_addr.push_back(a);
          p_word.push_back(w);
        end else if (tag == "E") begin
          cnt = $fscanf(fd, "%h", v);
          if (cnt != 1) begin
            $display("an expected value in the trace file is malformed");
            tb_errors++;
          end
          e_val.push_back(v);
        end else if (tag == "X") begin
          prog_len.push_back(p_word.size() - prog_start[$]);
          exp_len.push_back(e_val.size() - exp_start[$]);
          watch_cycles += 4 * prog_len[$] + 50;
        end else begin
          $display("the trace file holds an unknown record %s", tag);
          tb_errors++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic load_program(input int t);
    for (int i = 0; i < prog_len[t]; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;                         // boot port, core idle
      prog_addr <= p_addr[prog_start[t] + i];
      prog_data <= p_word[prog_start[t] + i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    chk.start_test(names[t]);
    for (int i = 0; i < exp_len[t]; i++) begin
      chk.add_expected(e_val[exp_start[t] + i]);
    end
  endtask

  task automatic run_program(input int t);
    if (t > 0 && done !== 1'b1) begin            // level from the previous run
      $display("done fell before the req of test %s", names[t]);
      tb_errors++;
    end
    @(posedge clk);
    req <= 1'b1;
    @(posedge clk);
    req <= 1'b0;
    do begin
      @(posedge clk);
    end while (out_valid !== 1'b1 && done !== 1'b1);
    if (done !== 1'b1) begin
      req <= 1'b1;                               // busy core, a restart repeats outputs
      @(posedge clk);
      req <= 1'b0;
    end
    while (done !== 1'b1) @(posedge clk);
    repeat (4) begin
      @(posedge clk);
      if (done !== 1'b1) begin
        $display("done did not hold after test %s", names[t]);
        tb_errors++;
      end
    end
  endtask

  initial begin
    arst_n       = 1'b0;
    req          = 1'b0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    tb_errors    = 0;
    watch_cycles = rst_cycles + 20;
    read_trace();
    if (names.size() == 0) begin
      $display("the trace file holds no complete test");
      tb_errors++;
    end
    repeat (rst_cycles) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    if (done !== 1'b0 || out_valid !== 1'b0 || DUT.run !== 1'b0 || DUT.pc !== '0) begin
      $display("done, out_valid, run or pc not clear after reset");
      tb_errors++;
    end
    foreach (names[t]) begin
      load_program(t);                           // no reset between tests
      run_program(t);
    end
    $display("errors: %0d total, %0d from checker, %0d from testbench",
             chk_errors + tb_errors, chk_errors, tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #1;                                          // budget known after the trace read
    repeat (watch_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles without the core reaching done",
             watch_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule : cpu_tb

`default_nettype wire

// File: sim/cpu_checker.sv
// output checker: compares the out port stream and the output count with the trace
`default_nettype none

module cpu_checker import cpu_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic                  out_valid,
  input  wire logic [data_width-1:0] out_data,
  input  wire logic                  done,
  output int                         errors
);

  string                 test_name = "none";
  logic [data_width-1:0] exp_q[$];               // expected stream of this test
  int                    seen = 0;               // outputs taken so far
  int                    err_cnt = 0;
  logic                  done_d;                 // for the done edge

  assign errors = err_cnt;

  task automatic start_test(input string name);
    test_name = name;
    exp_q.delete();
    seen = 0;
  endtask

  task automatic add_expected(input logic [data_width-1:0] value);
    exp_q.push_back(value);
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done_d <= 1'b0;
    end else begin
      if (out_valid === 1'b1) begin              // no back-pressure, take every pulse
        if (seen < exp_q.size() && out_data !== exp_q[seen]) begin
          $display("[ERROR] %s output %0d: expected 0x%02h, actual 0x%02h",
                   test_name, seen, exp_q[seen], out_data);
          err_cnt++;
        end
        seen++;
      end
      if (done === 1'b1 && done_d !== 1'b1 && seen != exp_q.size()) begin
        $display("test %s finished with %0d outputs where %0d were expected",
                 test_name, seen, exp_q.size());
        err_cnt++;
      end
      done_d <= done;
    end
  end

endmodule : cpu_checker

`default_nettype wire

// File: design/cpu_top.sv
// cpu top: single-cycle accumulator core with write-back select and output port
`default_nettype none

module cpu_top import cpu_pkg::*; #(
  parameter int pc_width = 10
) (
  input  wire logic                   clk,
  input  wire logic                   arst_n,
  input  wire logic                   req,
  input  wire logic                   prog_we,
  input  wire logic [pc_width-1:0]    prog_addr,
  input  wire logic [instr_width-1:0] prog_data,
  output logic                        done,
  output logic                        out_valid,
  output logic      [data_width-1:0]  out_data
);

  logic [instr_width-1:0]    instr;
  logic [pc_width-1:0]       pc;
  logic                      run;
  logic [reg_addr_width-1:0] rd_addr_a, rd_addr_b, wr_addr;
  logic                      reg_we, flag_en, sc_clr, mem_we, out_en;
  logic                      halt, branch_taken;
  logic [br_off_width-1:0]   branch_off;
  alu_cmd_e                  alu_cmd;
  wb_sel_e                   wb_sel;
  logic [data_width-1:0]     imm, dat_a, dat_b, result, mem_rdata, wr_data;
  logic                      zero_q, pari_q, sc_q;

  fetch_unit #(.pc_width(pc_width)) u_fetch (
    .clk, .arst_n, .req, .prog_we, .prog_addr, .prog_data,
    .halt, .branch_taken, .branch_off,
    .instr, .pc, .run, .done
  );

  decoder u_dec (
    .instr, .zero_q, .pari_q, .sc_q,
    .rd_addr_a, .rd_addr_b, .wr_addr, .reg_we,
    .alu_cmd, .flag_en, .sc_clr,
    .mem_we, .wb_sel, .imm, .out_en,
    .halt, .branch_taken, .branch_off
  );

  reg_file u_rf (
    .clk, .arst_n, .wr_en(reg_we), .wr_addr, .wr_data,
    .rd_addr_a, .rd_addr_b, .dat_a, .dat_b
  );

  exec_unit u_exec (
    .clk, .arst_n, .alu_cmd, .in_a(dat_a), .in_b(dat_b),
    .flag_en, .sc_clr, .result, .zero_q, .pari_q, .sc_q
  );

  data_mem u_dmem (
    .clk, .wr_en(mem_we), .addr(dat_a), .wr_data(dat_b), .rd_data(mem_rdata)
  );

  // write-back source
  always_comb begin
    unique case (wb_sel)
      WB_MEM:  wr_data = mem_rdata;     // LW
      WB_IMM:  wr_data = imm;           // LDI
      default: wr_data = result;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) out_valid <= 1'b0;
    else         out_valid <= out_en;   // one cycle after OUT
  end

  always_ff @(posedge clk) begin
    if (out_en) out_data <= dat_a;      // ra captured
  end

endmodule : cpu_top

`default_nettype wire

// File: design/data_mem.sv
// data memory: 256 bytes, clocked write, combinational read
`default_nettype none

module data_mem import cpu_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  wr_en,
  input  wire logic [data_width-1:0] addr,     // from ra
  input  wire logic [data_width-1:0] wr_data,  // from rb
  output logic      [data_width-1:0] rd_data
);

  logic [data_width-1:0] mem [2**data_width];  // undefined at power-up

  always_ff @(posedge clk) begin
    if (wr_en) mem[addr] <= wr_data;
  end

  assign rd_data = mem[addr];

endmodule : data_mem

`default_nettype wire

// File: design/exec_unit.sv
// execute unit: ALU with registered carry/shift, zero and parity flags
`default_nettype none

module exec_unit import cpu_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire alu_cmd_e              alu_cmd,
  input  wire logic [data_width-1:0] in_a,
  input  wire logic [data_width-1:0] in_b,
  input  wire logic                  flag_en,   // ADD, XOR, SHL
  input  wire logic                  sc_clr,    // CLC
  output logic      [data_width-1:0] result,
  output logic                       zero_q,
  output logic                       pari_q,
  output logic                       sc_q
);

  logic sc_next;                        // sc after this op

  always_comb begin
    sc_next = sc_q;                     // held unless op drives it
    unique case (alu_cmd)
      ALU_ADD:    {sc_next, result} = in_a + in_b;   // carry out to sc
      ALU_XOR:    result = in_a ^ in_b;
      ALU_SHL:    {sc_next, result} = {in_a, sc_q};  // rotate through sc
      ALU_PASS_B: result = in_b;
      default:    result = in_b;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      zero_q <= 1'b0;
      pari_q <= 1'b0;
      sc_q   <= 1'b0;
    end else begin
      if (flag_en) begin
        zero_q <= (result == '0);
        pari_q <= ^result;              // odd parity
      end
      if (sc_clr)       sc_q <= 1'b0;
      else if (flag_en) sc_q <= sc_next;
    end
  end

  // decoder never mixes an ALU op with CLC
  assert property (@(posedge clk) disable iff (!arst_n) !(flag_en && sc_clr));

endmodule : exec_unit

`default_nettype wire

// File: design/reg_file.sv
// register file: eight data registers, two combinational reads, one clocked write
`default_nettype none

module reg_file import cpu_pkg::*; (
  input  wire logic                      clk,
  input  wire logic                      arst_n,
  input  wire logic                      wr_en,
  input  wire logic [reg_addr_width-1:0] wr_addr,
  input  wire logic [data_width-1:0]     wr_data,
  input  wire logic [reg_addr_width-1:0] rd_addr_a,
  input  wire logic [reg_addr_width-1:0] rd_addr_b,
  output logic      [data_width-1:0]     dat_a,
  output logic      [data_width-1:0]     dat_b
);

  logic [data_width-1:0] regs [2**reg_addr_width];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**reg_addr_width; i++) begin
        regs[i] <= '0;                  // all registers cleared
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // read before write within the cycle
  assign dat_a = regs[rd_addr_a];
  assign dat_b = regs[rd_addr_b];

endmodule : reg_file

`default_nettype wire

// File: design/decoder.sv
// decoder: instruction fields to datapath controls, branch condition against flags
`default_nettype none

module decoder import cpu_pkg::*; (
  input  wire logic [instr_width-1:0]    instr,
  input  wire logic                      zero_q,
  input  wire logic                      pari_q,
  input  wire logic                      sc_q,
  output logic      [reg_addr_width-1:0] rd_addr_a,
  output logic      [reg_addr_width-1:0] rd_addr_b,
  output logic      [reg_addr_width-1:0] wr_addr,
  output logic                           reg_we,
  output alu_cmd_e                       alu_cmd,
  output logic                           flag_en,
  output logic                           sc_clr,
  output logic                           mem_we,
  output wb_sel_e                        wb_sel,
  output logic      [data_width-1:0]     imm,
  output logic                           out_en,
  output logic                           halt,
  output logic                           branch_taken,
  output logic      [br_off_width-1:0]   branch_off
);

  op_e   op;
  cond_e cond;
  sys_e  sys;
  logic  cond_ok;                       // condition met, any opcode

  assign op   = op_e'(instr[8:6]);
  assign cond = cond_e'(instr[5:4]);
  assign sys  = sys_e'(instr[5:3]);

  // fixed field positions
  assign rd_addr_a  = instr[2:0];       // ra
  assign rd_addr_b  = instr[5:3];       // rb
  assign imm        = {2'b00, instr[5:0]};
  assign branch_off = instr[3:0];

  always_comb begin
    unique case (cond)
      COND_ALWAYS: cond_ok = 1'b1;
      COND_ZERO:   cond_ok = zero_q;
      COND_ODD:    cond_ok = pari_q;
      COND_CARRY:  cond_ok = sc_q;
    endcase
  end

  always_comb begin
    wr_addr      = rd_addr_a;           // in place by default
    reg_we       = 1'b0;
    alu_cmd      = ALU_PASS_B;
    flag_en      = 1'b0;
    sc_clr       = 1'b0;
    mem_we       = 1'b0;
    wb_sel       = WB_ALU;
    out_en       = 1'b0;
    halt         = 1'b0;
    branch_taken = 1'b0;
    unique case (op)
      OP_ADD: begin reg_we = 1'b1; flag_en = 1'b1; alu_cmd = ALU_ADD; end
      OP_XOR: begin reg_we = 1'b1; flag_en = 1'b1; alu_cmd = ALU_XOR; end
      OP_SHL: begin reg_we = 1'b1; flag_en = 1'b1; alu_cmd = ALU_SHL; end
      OP_LDI: begin
        reg_we  = 1'b1;
        wr_addr = '0;                   // always r0
        wb_sel  = WB_IMM;
      end
      OP_LW: begin
        reg_we  = 1'b1;
        wr_addr = rd_addr_b;            // loads land in rb
        wb_sel  = WB_MEM;
      end
      OP_SW:  mem_we       = 1'b1;
      OP_BR:  branch_taken = cond_ok;
      OP_SYS: begin
        case (sys)
          SYS_HALT: halt   = 1'b1;
          SYS_OUT:  out_en = 1'b1;
          SYS_CLC:  sc_clr = 1'b1;
          default:  ;                   // no-op
        endcase
      end
    endcase
  end

endmodule : decoder

`default_nettype wire

// File: design/fetch_unit.sv
// fetch unit: program counter, boot-loaded instruction memory and run/done control
`default_nettype none

module fetch_unit import cpu_pkg::*; #(
  parameter int pc_width = 10
) (
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire logic                    req,          // start pulse
  input  wire logic                    prog_we,      // boot write strobe
  input  wire logic [pc_width-1:0]     prog_addr,
  input  wire logic [instr_width-1:0]  prog_data,
  input  wire logic                    halt,
  input  wire logic                    branch_taken,
  input  wire logic [br_off_width-1:0] branch_off,   // signed
  output logic      [instr_width-1:0]  instr,
  output logic      [pc_width-1:0]     pc,
  output logic                         run,
  output logic                         done
);

  logic [instr_width-1:0] imem [2**pc_width];  // program store
  logic [pc_width-1:0]    target;              // relative branch target

  // sign-extend offset, relative to the branch itself
  assign target = pc + {{(pc_width-br_off_width){branch_off[br_off_width-1]}}, branch_off};

  // idle core sees a no-op so nothing writes
  assign instr = run ? imem[pc] : nop_word;

  always_ff @(posedge clk) begin
    if (prog_we && !run) imem[prog_addr] <= prog_data;  // boot port, idle only
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc   <= '0;
      run  <= 1'b0;
      done <= 1'b0;
    end else if (!run) begin
      if (req) begin                    // start from address 0
        pc   <= '0;
        run  <= 1'b1;
        done <= 1'b0;
      end
    end else if (halt) begin            // HALT ends the run, pc stays
      run  <= 1'b0;
      done <= 1'b1;
    end else begin
      pc <= branch_taken ? target : pc + 1'b1;
    end
  end

  // loader must wait for done before touching the program
  assert property (@(posedge clk) disable iff (!arst_n) !(prog_we && run));
  assert property (@(posedge clk) disable iff (!arst_n) !(done && run));

endmodule : fetch_unit

`default_nettype wire

// File: design/cpu_pkg.sv
// cpu package: shared widths, instruction field encodings and datapath selects
`default_nettype none

package cpu_pkg;

  localparam int instr_width    = 9;    // machine word
  localparam int data_width     = 8;    // regs, memory, datapath
  localparam int reg_addr_width = 3;    // eight registers
  localparam int br_off_width   = 4;    // signed relative branch offset

  // opcode in instr[8:6]
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,                      // ra <= ra + rb, carry to sc
    OP_XOR = 3'd1,                      // ra <= ra ^ rb
    OP_SHL = 3'd2,                      // ra <= {ra[6:0], sc}, ra[7] to sc
    OP_LDI = 3'd3,                      // r0 <= zext imm6
    OP_LW  = 3'd4,                      // rb <= mem[ra]
    OP_SW  = 3'd5,                      // mem[ra] <= rb
    OP_BR  = 3'd6,                      // pc <= pc + off when cond holds
    OP_SYS = 3'd7                       // sub-code in instr[5:3]
  } op_e;

  // branch condition in instr[5:4]
  typedef enum logic [1:0] {
    COND_ALWAYS = 2'd0,
    COND_ZERO   = 2'd1,                 // zero flag set
    COND_ODD    = 2'd2,                 // parity flag set
    COND_CARRY  = 2'd3                  // sc set
  } cond_e;

  // system sub-code in instr[5:3], unlisted codes do nothing
  typedef enum logic [2:0] {
    SYS_HALT = 3'd0,
    SYS_OUT  = 3'd1,                    // ra to output port
    SYS_CLC  = 3'd2,                    // clear sc
    SYS_NOP  = 3'd7
  } sys_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_XOR    = 3'd1,
    ALU_SHL    = 3'd2,
    ALU_PASS_B = 3'd3
  } alu_cmd_e;

  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_IMM = 2'd2
  } wb_sel_e;

  // word fed to the decoder while the core is idle
  localparam logic [instr_width-1:0] nop_word = {OP_SYS, SYS_NOP, 3'b000};

endpackage : cpu_pkg

`default_nettype wire
